//--- source/rv_arch_pkg.sv
// Architectural constants for the RV32 write-back end.
// Data width, register file and CSR file sizes with their address types.
`default_nettype none

package rv_arch_pkg;

    // Data and pc width.
    localparam int xlen = 32;

    // General register file.
    localparam int gpr_count = 32;
    localparam int gpr_addr_w = $clog2(gpr_count);

    // Only four plain CSRs are modelled.
    localparam int csr_count = 4;
    localparam int csr_addr_w = $clog2(csr_count);

    typedef logic [xlen-1:0] word_t;

    typedef logic [gpr_addr_w-1:0] gpr_addr_t;

    typedef logic [csr_addr_w-1:0] csr_addr_t;

endpackage

`default_nettype wire

//--- source/wb_bus_pkg.sv
// Bus structs of the write-back end.
// Memory-to-write-back operation, register write ports and commit record.
`default_nettype none

package wb_bus_pkg;

    import rv_arch_pkg::*;

    // One operation handed over by the memory stage.
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        word_t     alu_out;
        word_t     csr_out;
        word_t     rdata;
        gpr_addr_t rd;
        csr_addr_t csr_rd;
        logic      write_gpr;
        logic      write_csr;
        logic      mem_to_reg;
        logic      system_halt;
    } mem_wb_pkt_t;

    // General register write port.
    typedef struct packed {
        logic      en;
        gpr_addr_t addr;
        word_t     data;
    } gpr_wr_t;

    // CSR write port.
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        word_t     data;
    } csr_wr_t;

    // Record of one retired instruction.
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        gpr_addr_t rd;
        word_t     rf_data;
        csr_addr_t csr_rd;
        word_t     csr_data;
        logic      reg_wr;
        logic      csr_wr;
        logic      halt;
    } commit_rec_t;

endpackage

`default_nettype wire

//--- source/wb_op_queue.sv
// Credit-fed operation FIFO between the memory and write-back stages.
`default_nettype none
`timescale 1ns/1ps

module wb_op_queue
    import wb_bus_pkg::*;
#(
    parameter int queue_depth = 4
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        in_valid,
    input  mem_wb_pkt_t in_pkt,
    output logic        in_credit,

    output logic        head_valid,
    output mem_wb_pkt_t head_pkt,
    input  logic        pop
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    mem_wb_pkt_t       mem [queue_depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;

    // Wrap at the last entry for any depth.
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(queue_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_pkt   = mem[rd_ptr];

    // Payload storage.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end

            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // One credit back to the sender per released entry.
            in_credit <= pop;
        end
    end

endmodule

`default_nettype wire

//--- source/wb_retire.sv
// Retire stage of write-back.
// Value selection, register writes, forwarding, commit credits and halt.
`default_nettype none
`timescale 1ns/1ps

module wb_retire
    import rv_arch_pkg::*;
    import wb_bus_pkg::*;
#(
    parameter int commit_credits = 2
) (
    input  logic        clk,
    input  logic        rst_n,

    // Head of the operation queue.
    input  logic        head_valid,
    input  mem_wb_pkt_t head_pkt,
    output logic        pop,

    // Register file writes.
    output gpr_wr_t     gpr_wr,
    output csr_wr_t     csr_wr,

    // Forwarding data.
    output word_t       rs1_fwd,
    output word_t       rs2_fwd,
    output word_t       csr_fwd,

    // Commit sink.
    output logic        commit_valid,
    output commit_rec_t commit,
    input  logic        commit_credit,

    output logic        halted
);

    localparam int cred_w = $clog2(commit_credits + 1);

    logic [cred_w-1:0] credit_cnt;
    logic              retire;
    word_t             rf_data;
    word_t             csr_data;

    // Retire needs an operation, a sink credit and a running core.
    assign retire = head_valid && (credit_cnt != '0) && !halted;
    assign pop    = retire;

    // Load data wins when mem_to_reg is set.
    assign rf_data  = head_pkt.mem_to_reg ? head_pkt.rdata : head_pkt.alu_out;
    assign csr_data = head_pkt.csr_out;

    assign gpr_wr.en   = retire && head_pkt.write_gpr;
    assign gpr_wr.addr = head_pkt.rd;
    assign gpr_wr.data = rf_data;

    assign csr_wr.en   = retire && head_pkt.write_csr;
    assign csr_wr.addr = head_pkt.csr_rd;
    assign csr_wr.data = csr_data;

    // Only meaningful in a retire cycle.
    assign rs1_fwd = rf_data;
    assign rs2_fwd = rf_data;
    assign csr_fwd = csr_data;

    // Credits held toward the commit sink.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= cred_w'(commit_credits);
        end else begin
            case ({retire, commit_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            commit_valid <= retire;
            // Sticky until reset.
            if (retire && head_pkt.system_halt) begin
                halted <= 1'b1;
            end
        end
    end

    // Commit record payload.
    always_ff @(posedge clk) begin
        if (retire) begin
            commit.pc       <= head_pkt.pc;
            commit.inst     <= head_pkt.inst;
            commit.rd       <= head_pkt.rd;
            commit.rf_data  <= rf_data;
            commit.csr_rd   <= head_pkt.csr_rd;
            commit.csr_data <= csr_data;
            commit.reg_wr   <= head_pkt.write_gpr;
            commit.csr_wr   <= head_pkt.write_csr;
            commit.halt     <= head_pkt.system_halt;
        end
    end

endmodule

`default_nettype wire

//--- source/gpr_file.sv
// General register file with x0 tied to zero.
// Two combinational read ports with write-through bypass.
`default_nettype none
`timescale 1ns/1ps

module gpr_file
    import rv_arch_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  gpr_wr_t   wr,

    input  gpr_addr_t rs1_addr,
    output word_t     rs1_data,
    input  gpr_addr_t rs2_addr,
    output word_t     rs2_data
);

    word_t regs [gpr_count];

    // x0 first, then the write in flight, then the array.
    function automatic word_t read_port(input gpr_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr.en && (wr.addr == addr)) begin
            return wr.data;
        end
        return regs[addr];
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < gpr_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.addr != '0)) begin
            // Writes to x0 are dropped.
            regs[wr.addr] <= wr.data;
        end
    end

endmodule

`default_nettype wire

//--- source/csr_file.sv
// Four-entry CSR file with one write and one bypassed read port.
`default_nettype none
`timescale 1ns/1ps

module csr_file
    import rv_arch_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  csr_wr_t   wr,

    input  csr_addr_t rs_addr,
    output word_t     rs_data
);

    word_t csrs [csr_count];

    // Same-cycle write is visible on the read port.
    assign rs_data = (wr.en && (wr.addr == rs_addr)) ? wr.data : csrs[rs_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < csr_count; i++) begin
                csrs[i] <= '0;
            end
        end else if (wr.en) begin
            csrs[wr.addr] <= wr.data;
        end
    end

endmodule

`default_nettype wire

//--- source/wb_top.sv
// Write-back subsystem top level.
// Operation queue, retire stage, general register file and CSR file.
`default_nettype none
`timescale 1ns/1ps

module wb_top
    import rv_arch_pkg::*;
    import wb_bus_pkg::*;
#(
    parameter int queue_depth    = 4,
    parameter int commit_credits = 2
) (
    input  logic        clk,
    input  logic        rst_n,

    // From the memory stage.
    input  logic        in_valid,
    input  mem_wb_pkt_t in_pkt,
    output logic        in_credit,

    // To the commit sink.
    output logic        commit_valid,
    output commit_rec_t commit,
    input  logic        commit_credit,

    // Forwarding data.
    output word_t       rs1_fwd,
    output word_t       rs2_fwd,
    output word_t       csr_fwd,

    // Register read ports.
    input  gpr_addr_t   rs1_addr,
    output word_t       rs1_data,
    input  gpr_addr_t   rs2_addr,
    output word_t       rs2_data,
    input  csr_addr_t   csr_rs_addr,
    output word_t       csr_rs_data,

    output logic        halted
);

    logic        head_valid;
    mem_wb_pkt_t head_pkt;
    logic        pop;
    gpr_wr_t     gpr_wr;
    csr_wr_t     csr_wr;

    wb_op_queue #(
        .queue_depth (queue_depth)
    ) u_wb_op_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .in_credit  (in_credit),
        .head_valid (head_valid),
        .head_pkt   (head_pkt),
        .pop        (pop)
    );

    wb_retire #(
        .commit_credits (commit_credits)
    ) u_wb_retire (
        .clk           (clk),
        .rst_n         (rst_n),
        .head_valid    (head_valid),
        .head_pkt      (head_pkt),
        .pop           (pop),
        .gpr_wr        (gpr_wr),
        .csr_wr        (csr_wr),
        .rs1_fwd       (rs1_fwd),
        .rs2_fwd       (rs2_fwd),
        .csr_fwd       (csr_fwd),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .commit_credit (commit_credit),
        .halted        (halted)
    );

    gpr_file u_gpr_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (gpr_wr),
        .rs1_addr (rs1_addr),
        .rs1_data (rs1_data),
        .rs2_addr (rs2_addr),
        .rs2_data (rs2_data)
    );

    csr_file u_csr_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (csr_wr),
        .rs_addr (csr_rs_addr),
        .rs_data (csr_rs_data)
    );

endmodule

`default_nettype wire

//--- test/wb_tb.sv
// Testbench for the write-back subsystem.
// LFSR stimulus with credit bookkeeping, reference model and per-cycle checks.
`default_nettype none
`timescale 1ns/1ps

module wb_tb
    import rv_arch_pkg::*;
    import wb_bus_pkg::*;
();

    localparam int queue_depth    = 4;
    localparam int commit_credits = 2;
    localparam int num_pkts       = 400;
    localparam int timeout_cycles = num_pkts * 10 + 200;

    typedef logic [159:0] cmp_t;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        in_valid = 1'b0;
    mem_wb_pkt_t in_pkt = '0;
    logic        in_credit;
    logic        commit_valid;
    commit_rec_t commit;
    logic        commit_credit = 1'b0;
    word_t       rs1_fwd;
    word_t       rs2_fwd;
    word_t       csr_fwd;
    gpr_addr_t   rs1_addr = '0;
    word_t       rs1_data;
    gpr_addr_t   rs2_addr = '0;
    word_t       rs2_data;
    csr_addr_t   csr_rs_addr = '0;
    word_t       csr_rs_data;
    logic        halted;

    logic [31:0] lfsr_state = 32'hf68a_4cc8;
    mem_wb_pkt_t sent_q [$];
    int          sent_count = 0;
    int          pulse_count = 0;
    int          credit_returns = 0;
    int          commit_count = 0;
    int          pulses_seen = 0;
    int          cycle_count = 0;
    logic        halt_seen = 1'b0;
    logic        have_prev = 1'b0;
    word_t       gpr_model [gpr_count] = '{default: '0};
    word_t       csr_model [csr_count] = '{default: '0};

    // Reads of the previous cycle, checked once its retire is known.
    gpr_addr_t   prev_rs1_addr;
    gpr_addr_t   prev_rs2_addr;
    csr_addr_t   prev_csr_addr;
    word_t       prev_rs1_data;
    word_t       prev_rs2_data;
    word_t       prev_csr_data;
    word_t       prev_rs1_fwd;
    word_t       prev_rs2_fwd;
    word_t       prev_csr_fwd;

    wb_top #(
        .queue_depth    (queue_depth),
        .commit_credits (commit_credits)
    ) u_wb_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pkt        (in_pkt),
        .in_credit     (in_credit),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .commit_credit (commit_credit),
        .rs1_fwd       (rs1_fwd),
        .rs2_fwd       (rs2_fwd),
        .csr_fwd       (csr_fwd),
        .rs1_addr      (rs1_addr),
        .rs1_data      (rs1_data),
        .rs2_addr      (rs2_addr),
        .rs2_data      (rs2_data),
        .csr_rs_addr   (csr_rs_addr),
        .csr_rs_data   (csr_rs_data),
        .halted        (halted)
    );

    always #50 clk = ~clk;

    // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic make_packet(input logic halt, output mem_wb_pkt_t pkt);
        logic [31:0] r;
        random_bits(32, r);
        pkt.pc = r;
        random_bits(32, r);
        pkt.inst = r;
        random_bits(32, r);
        pkt.alu_out = r;
        random_bits(32, r);
        pkt.csr_out = r;
        random_bits(32, r);
        pkt.rdata = r;
        random_bits(5, r);
        pkt.rd = r[4:0];
        random_bits(2, r);
        pkt.csr_rd = r[1:0];
        random_bits(3, r);
        pkt.write_gpr = r[0];
        pkt.write_csr = r[1];
        pkt.mem_to_reg = r[2];
        pkt.system_halt = halt;
    endtask

    // Expected retire record of one operation.
    function automatic commit_rec_t expected_commit(input mem_wb_pkt_t p);
        commit_rec_t rec;
        rec.pc       = p.pc;
        rec.inst     = p.inst;
        rec.rd       = p.rd;
        rec.rf_data  = p.mem_to_reg ? p.rdata : p.alu_out;
        rec.csr_rd   = p.csr_rd;
        rec.csr_data = p.csr_out;
        rec.reg_wr   = p.write_gpr;
        rec.csr_wr   = p.write_csr;
        rec.halt     = p.system_halt;
        return rec;
    endfunction

    function automatic word_t gpr_expect(input gpr_addr_t addr, input logic wr_en,
                                         input gpr_addr_t wr_addr, input word_t wr_data);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && (wr_addr == addr)) begin
            return wr_data;
        end
        return gpr_model[addr];
    endfunction

    task automatic check_equal(input cmp_t actual, input cmp_t expected, input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    // Memory stage, commit sink and read port stimulus.
    always @(posedge clk) begin : drive
        logic [31:0] r;
        mem_wb_pkt_t pkt;
        int          credits;
        if (rst_n) begin
            credits = queue_depth - sent_count + credit_returns;
            random_bits(2, r);
            if ((sent_count < num_pkts) && (credits > 0) && (r[1:0] != 2'b00)) begin
                make_packet(sent_count == num_pkts - 1, pkt);
                in_valid <= 1'b1;
                in_pkt   <= pkt;
                sent_q.push_back(pkt);
                sent_count++;
            end else begin
                in_valid <= 1'b0;
            end
            // Return a sink credit only for a record already consumed.
            random_bits(1, r);
            if ((commit_count > pulse_count) && r[0]) begin
                commit_credit <= 1'b1;
                pulse_count++;
            end else begin
                commit_credit <= 1'b0;
            end
            random_bits(5, r);
            rs1_addr <= r[4:0];
            random_bits(5, r);
            rs2_addr <= r[4:0];
            random_bits(2, r);
            csr_rs_addr <= r[1:0];
        end
    end

    // Compares DUT outputs against the model in the middle of each cycle.
    always @(negedge clk) begin : compare
        commit_rec_t exp;
        word_t       want;
        if (!rst_n) begin
            have_prev = 1'b0;
        end else begin
            if (in_credit) begin
                credit_returns++;
            end
            check_equal(cmp_t'(credit_returns <= sent_count), cmp_t'(1'b1),
                        "sender credits above queue depth");
            if (commit_valid) begin
                if (halt_seen) begin
                    abort_run("A commit appeared after the halt instruction retired.");
                end
                if (commit_count >= sent_q.size()) begin
                    abort_run("A commit appeared with no operation in flight.");
                end
                exp = expected_commit(sent_q[commit_count]);
                check_equal(cmp_t'(commit), cmp_t'(exp), "commit record");
                commit_count++;
                check_equal(cmp_t'(commit_count <= commit_credits + pulses_seen), cmp_t'(1'b1),
                            "commit without a sink credit");
                check_equal(cmp_t'(prev_rs1_fwd), cmp_t'(exp.rf_data), "rs1 forwarding");
                check_equal(cmp_t'(prev_rs2_fwd), cmp_t'(exp.rf_data), "rs2 forwarding");
                check_equal(cmp_t'(prev_csr_fwd), cmp_t'(exp.csr_data), "csr forwarding");
            end
            if (have_prev) begin
                want = gpr_expect(prev_rs1_addr, commit_valid && exp.reg_wr, exp.rd, exp.rf_data);
                check_equal(cmp_t'(prev_rs1_data), cmp_t'(want), "rs1 read data");
                want = gpr_expect(prev_rs2_addr, commit_valid && exp.reg_wr, exp.rd, exp.rf_data);
                check_equal(cmp_t'(prev_rs2_data), cmp_t'(want), "rs2 read data");
                if (commit_valid && exp.csr_wr && (exp.csr_rd == prev_csr_addr)) begin
                    want = exp.csr_data;
                end else begin
                    want = csr_model[prev_csr_addr];
                end
                check_equal(cmp_t'(prev_csr_data), cmp_t'(want), "csr read data");
            end
            if (commit_valid) begin
                if (exp.reg_wr && (exp.rd != '0)) begin
                    gpr_model[exp.rd] = exp.rf_data;
                end
                if (exp.csr_wr) begin
                    csr_model[exp.csr_rd] = exp.csr_data;
                end
                halt_seen = exp.halt;
            end
            check_equal(cmp_t'(halted), cmp_t'(halt_seen), "halted flag");
            prev_rs1_addr = rs1_addr;
            prev_rs2_addr = rs2_addr;
            prev_csr_addr = csr_rs_addr;
            prev_rs1_data = rs1_data;
            prev_rs2_data = rs2_data;
            prev_csr_data = csr_rs_data;
            prev_rs1_fwd  = rs1_fwd;
            prev_rs2_fwd  = rs2_fwd;
            prev_csr_fwd  = csr_fwd;
            have_prev     = 1'b1;
            if (commit_credit) begin
                pulses_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            abort_run($sformatf("Timed out after %0d cycles before the run finished.",
                                cycle_count));
        end
    end

    initial begin
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        while (!(halt_seen && (commit_count == pulse_count))) begin
            @(posedge clk);
        end
        // Extra sink credits after the halt must not bring out a commit.
        repeat (20) @(posedge clk);
        check_equal(cmp_t'(commit_count), cmp_t'(num_pkts), "number of commits");
        check_equal(cmp_t'(queue_depth - sent_count + credit_returns), cmp_t'(queue_depth),
                    "sender credits after halt");
        check_equal(cmp_t'(halted), cmp_t'(1'b1), "halted at end of run");
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/rv_arch_pkg.sv
source/wb_bus_pkg.sv
source/wb_op_queue.sv
source/wb_retire.sv
source/gpr_file.sv
source/csr_file.sv
source/wb_top.sv
test/wb_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the write-back testbench with Verilator and run it.
# The result is decided by searching the simulation log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module wb_tb \
    -f sources.f -o wb_sim \
    && ./obj_dir/wb_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "TB PASSED" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
